/* Bender.yml */
package:
  name: exec_core

sources:
  # Package first, then the RTL from leaf modules up to the top level
  - files:
      - verilog/cpuPkg.sv
      - verilog/instrDecoder.sv
      - verilog/regFile.sv
      - verilog/alu.sv
      - verilog/statusReg.sv
      - verilog/execCore.sv

  # Testbench, only for simulation
  - target: test
    files:
      - verification/execCoreTb.sv

/* flist.f */
verilog/cpuPkg.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/alu.sv
verilog/statusReg.sv
verilog/execCore.sv
verification/execCoreTb.sv

/* verification/execCoreTb.sv */
/*
 * Execution core testbench with clock and reset, xorshift
 * instruction generator, register and flag model and assertions
 */
module execCoreTb import cpuPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ClkPeriod      = 40;
	localparam int InputDelay     = 2;
	localparam int CheckLead      = 2;
	localparam int ResetWaitLimit = 20;
	localparam int DrainLimit     = 20;
	localparam int RandomCount    = 600;

	// DUT ports
	logic        clk;
	logic        reset;
	logic [15:0] instr;
	logic        instrValid;
	logic        wbValid;
	logic [3:0]  wbAddr;
	logic [15:0] wbData;
	logic [4:0]  flags;

	// Reference state
	logic [15:0] modelRegs [16];
	logic [4:0]  modelFlags;

	// Bookkeeping
	int          errorCount;
	int          checkCount;
	int          issuedCount;
	int          issueSeq;
	int          checkedSeq;
	string       testName;
	string       checkName;
	logic [31:0] rngState;

	execCore u_dut (
		.clk        (clk),
		.reset      (reset),
		.instr      (instr),
		.instrValid (instrValid),
		.wbValid    (wbValid),
		.wbAddr     (wbAddr),
		.wbData     (wbData),
		.flags      (flags)
	);

	initial
	begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	// Reset spans three rising edges
	initial
	begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#(InputDelay);
		reset = 1'b0;
	end

	// Xorshift32 step on the shared generator state
	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rngState = x;
		return x;
	endfunction

	function automatic logic [15:0] regForm(input logic [3:0] ext, input logic [3:0] rd,
		input logic [3:0] rs);
		return {OpRegGroup, rd, ext, rs};
	endfunction

	function automatic logic [15:0] immForm(input logic [3:0] op, input logic [3:0] rd,
		input logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic logic [3:0] extCode(input int idx);
		case (idx)
			0: return ExtAnd;
			1: return ExtOr;
			2: return ExtXor;
			3: return ExtLsh;
			4: return ExtAdd;
			5: return ExtSub;
			6: return ExtCmp;
			default: return ExtMov;
		endcase
	endfunction

	function automatic logic [3:0] immCode(input int idx);
		case (idx)
			0: return OpAndi;
			1: return OpOri;
			2: return OpXori;
			3: return OpAddi;
			4: return OpLshi;
			5: return OpSubi;
			6: return OpCmpi;
			7: return OpMovi;
			default: return OpLui;
		endcase
	endfunction

	// Opcodes with no meaning on this core
	function automatic logic [3:0] illegalCode(input int idx);
		case (idx)
			0: return 4'b0100;
			1: return 4'b0110;
			2: return 4'b0111;
			3: return 4'b1010;
			4: return 4'b1100;
			default: return 4'b1110;
		endcase
	endfunction

	// Mostly legal words, a few illegal opcodes and random extended codes
	// Selector, registers and codes come from separate bits of r
	function automatic logic [15:0] randomInstr(input logic [31:0] r);
		int sel;
		sel = int'(r[4:0]);
		if (sel < 14)
			return regForm(extCode(int'(r[27:25])), r[8:5], r[12:9]);
		if (sel < 28)
			return immForm(immCode(int'(r[31:24]) % 9), r[8:5], r[19:12]);
		if (sel < 30)
			return immForm(illegalCode(int'(r[31:24]) % 6), r[8:5], r[19:12]);
		return regForm(r[23:20], r[8:5], r[12:9]);
	endfunction

	// Signed 5-bit amount shifts left when positive and right logically when negative
	function automatic logic [15:0] shiftModel(input logic [15:0] value, input logic [4:0] field);
		int amount;
		amount = field[4] ? int'(field) - 32 : int'(field);
		if (amount >= 0)
			return value << amount;
		if (-amount >= 16)
			return 16'h0000;
		return value >> (-amount);
	endfunction

	// Expected writeback and next flags for one cycle
	task automatic predict(input logic [15:0] word, input logic valid, output logic wb,
		output logic [15:0] data, output logic [4:0] nextFlags);
		logic [3:0]  op;
		logic [15:0] a;
		logic [15:0] b;
		logic [16:0] wide;
		aluOpT       kind;
		op = word[15:12];
		a = modelRegs[word[11:8]];
		b = {8'h00, word[7:0]};
		kind = aluNop;
		data = '0;
		nextFlags = modelFlags;
		if (op == OpRegGroup)
		begin
			b = modelRegs[word[3:0]];
			case (word[7:4])
				ExtAnd:  kind = aluAnd;
				ExtOr:   kind = aluOr;
				ExtXor:  kind = aluXor;
				ExtLsh:  kind = aluLsh;
				ExtAdd:  kind = aluAdd;
				ExtSub:  kind = aluSub;
				ExtCmp:  kind = aluCmp;
				ExtMov:  kind = aluMov;
				default: kind = aluNop;
			endcase
		end
		else
		begin
			case (op)
				OpAndi:  kind = aluAnd;
				OpOri:   kind = aluOr;
				OpXori:  kind = aluXor;
				OpLshi:  kind = aluLsh;
				OpAddi:  kind = aluAdd;
				OpSubi:  kind = aluSub;
				OpCmpi:  kind = aluCmp;
				OpMovi:  kind = aluMov;
				OpLui:   kind = aluLui;
				default: kind = aluNop;
			endcase
			// Arithmetic, compare and move take a signed byte
			if (op == OpAddi || op == OpSubi || op == OpCmpi || op == OpMovi)
				b = {{8{word[7]}}, word[7:0]};
		end
		if (!valid)
			kind = aluNop;
		case (kind)
			aluAdd:
			begin
				wide = {1'b0, a} + {1'b0, b};
				data = wide[15:0];
				nextFlags[FlagC] = wide[16];
				// Overflow when the sign-extended sum leaves 16 bits
				wide = {a[15], a} + {b[15], b};
				nextFlags[FlagF] = wide[16] ^ wide[15];
			end
			aluSub:
			begin
				data = a - b;
				nextFlags[FlagC] = (a < b);
				wide = {a[15], a} - {b[15], b};
				nextFlags[FlagF] = wide[16] ^ wide[15];
			end
			aluCmp:
			begin
				nextFlags[FlagZ] = (a == b);
				nextFlags[FlagL] = (a < b);
				nextFlags[FlagN] = ($signed(a) < $signed(b));
			end
			aluAnd:  data = a & b;
			aluOr:   data = a | b;
			aluXor:  data = a ^ b;
			aluMov:  data = b;
			aluLsh:  data = shiftModel(a, b[4:0]);
			aluLui:  data = {b[7:0], 8'h00};
			default: data = '0;
		endcase
		wb = (kind != aluNop) && (kind != aluCmp);
	endtask

	task automatic reportMismatch(input string field, input logic [15:0] expected,
		input logic [15:0] actual);
		errorCount++;
		$display("Error: %s %s expected %h actual %h at %0t", checkName, field, expected,
			actual, $time);
	endtask

	// Drive one word shortly after the rising edge
	task automatic issue(input logic [15:0] word, input logic valid);
		@(posedge clk);
		#(InputDelay);
		instr = word;
		instrValid = valid;
		checkName = testName;
		issuedCount++;
		issueSeq = issuedCount;
	endtask

	task automatic closeRun();
		$display("Checks: %0d  Errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	endtask

	task automatic timeoutFail(input string what);
		$display("Timeout while waiting for %s", what);
		errorCount++;
		closeRun();
	endtask

	// Compare outputs shortly before each rising edge, then advance the model
	always
	begin : modelCheck
		logic        expWb;
		logic [15:0] expData;
		logic [4:0]  expFlagsNext;
		@(posedge clk);
		#(ClkPeriod - CheckLead);
		if (reset)
		begin
			for (int i = 0; i < 16; i++)
				modelRegs[i] = '0;
			modelFlags = '0;
		end
		else
		begin
			predict(instr, instrValid, expWb, expData, expFlagsNext);
			checkCount++;
			assert (flags === modelFlags)
			else reportMismatch("flags", {11'b0, modelFlags}, {11'b0, flags});
			assert (wbValid === expWb)
			else reportMismatch("wbValid", {15'b0, expWb}, {15'b0, wbValid});
			if (expWb)
			begin
				assert (wbAddr === instr[11:8])
				else reportMismatch("wbAddr", {12'b0, instr[11:8]}, {12'b0, wbAddr});
				assert (wbData === expData)
				else reportMismatch("wbData", expData, wbData);
				modelRegs[instr[11:8]] = expData;
			end
			modelFlags = expFlagsNext;
			checkedSeq = issueSeq;
		end
	end

	initial
	begin : stimulus
		int          waitCycles;
		logic [31:0] r;
		logic [3:0]  rd;
		logic [3:0]  rs;
		logic [7:0]  imm;
		instr = '0;
		instrValid = 1'b0;
		errorCount = 0;
		checkCount = 0;
		issuedCount = 0;
		issueSeq = 0;
		checkedSeq = 0;
		rngState = 32'heaf3_f839;
		testName = "reset";
		checkName = "reset";
		waitCycles = 0;
		while (reset !== 1'b0 && waitCycles < ResetWaitLimit)
		begin
			@(posedge clk);
			waitCycles++;
		end
		if (reset !== 1'b0)
			timeoutFail("reset release");
		else
		begin
			// Every register reads zero right after reset
			for (int j = 0; j < 16; j++)
				issue(regForm(ExtMov, 4'(j), 4'(j)), 1'b1);

			// Fill registers through LUI and ORI
			testName = "load";
			for (int j = 0; j < 16; j++)
			begin
				r = nextRandom();
				issue(immForm(OpLui, 4'(j), r[15:8]), 1'b1);
				issue(immForm(OpOri, 4'(j), r[7:0]), 1'b1);
			end

			// Each source is the previous destination
			testName = "regReg";
			rs = 4'd1;
			for (int i = 0; i < 48; i++)
			begin
				r = nextRandom();
				rd = r[3:0];
				case (i % 6)
					0: issue(regForm(ExtAdd, rd, rs), 1'b1);
					1: issue(regForm(ExtSub, rd, rs), 1'b1);
					2: issue(regForm(ExtAnd, rd, rs), 1'b1);
					3: issue(regForm(ExtOr, rd, rs), 1'b1);
					4: issue(regForm(ExtXor, rd, rs), 1'b1);
					default: issue(regForm(ExtMov, rd, rs), 1'b1);
				endcase
				rs = rd;
			end

			// Byte edges exercise sign and zero extension
			testName = "immediate";
			for (int k = 0; k < 9; k++)
			begin
				for (int m = 0; m < 5; m++)
				begin
					r = nextRandom();
					case (m)
						0: imm = 8'h00;
						1: imm = 8'h7f;
						2: imm = 8'h80;
						3: imm = 8'hff;
						default: imm = r[7:0];
					endcase
					issue(immForm(immCode(k), r[11:8], imm), 1'b1);
				end
			end

			// All 32 amounts through both shift forms
			testName = "shift";
			issue(immForm(OpLui, 4'd1, 8'h84), 1'b1);
			issue(immForm(OpOri, 4'd1, 8'h21), 1'b1);
			for (int amt = 0; amt < 32; amt++)
			begin
				r = nextRandom();
				issue(regForm(ExtMov, 4'd2, 4'd1), 1'b1);
				issue(immForm(OpLshi, 4'd2, {r[2:0], 5'(amt)}), 1'b1);
				issue(immForm(OpMovi, 4'd15, 8'(amt)), 1'b1);
				issue(regForm(ExtMov, 4'd3, 4'd1), 1'b1);
				issue(regForm(ExtLsh, 4'd3, 4'd15), 1'b1);
			end

			// Overflow, carry, borrow and compare flags in turn
			testName = "flags";
			issue(immForm(OpLui, 4'd4, 8'h7f), 1'b1);
			issue(immForm(OpOri, 4'd4, 8'hff), 1'b1);
			issue(immForm(OpAddi, 4'd4, 8'h01), 1'b1);
			issue(immForm(OpCmpi, 4'd4, 8'h80), 1'b1);
			issue(immForm(OpMovi, 4'd5, 8'hff), 1'b1);
			issue(immForm(OpAddi, 4'd5, 8'h01), 1'b1);
			issue(immForm(OpSubi, 4'd5, 8'h01), 1'b1);
			issue(regForm(ExtCmp, 4'd4, 4'd5), 1'b1);
			issue(regForm(ExtCmp, 4'd5, 4'd4), 1'b1);
			issue(regForm(ExtXor, 4'd4, 4'd4), 1'b1);
			issue(regForm(ExtCmp, 4'd4, 4'd4), 1'b1);

			// Long mixed run with idle cycles and illegal codes
			testName = "random";
			for (int i = 0; i < RandomCount; i++)
			begin
				r = nextRandom();
				issue(randomInstr(r), (nextRandom() & 32'h7) != 0);
			end
			issue(16'h0000, 1'b0);

			waitCycles = 0;
			while (checkedSeq != issuedCount && waitCycles < DrainLimit)
			begin
				@(posedge clk);
				waitCycles++;
			end
			if (checkedSeq != issuedCount)
				timeoutFail("the last check");
			else
				closeRun();
		end
	end

endmodule

/* verilog/alu.sv */
/*
 * ALU: arithmetic, logic, shift, move and LUI results,
 * next flag values and the mask of flags each operation touches
 */
module alu import cpuPkg::*;
(
	input  logic [DataWidth-1:0] operandA,
	input  logic [DataWidth-1:0] operandB,
	input  aluOpT                aluOp,
	output logic [DataWidth-1:0] result,
	output logic [FlagWidth-1:0] flagsNext,
	output logic [FlagWidth-1:0] flagMask
);

	// One extra bit holds carry out or borrow
	logic [DataWidth:0] sumWide;
	logic [DataWidth:0] diffWide;

	// Signed overflow for each direction
	logic addOverflow;
	logic subOverflow;

	// Shift amount is a signed 5-bit field of operand B
	logic signed [4:0] shiftAmount;
	logic [4:0]        shiftMag;
	logic [DataWidth-1:0] shiftResult;

	assign sumWide  = {1'b0, operandA} + {1'b0, operandB};
	assign diffWide = {1'b0, operandA} - {1'b0, operandB};

	// Same input signs but result sign flipped
	assign addOverflow = (operandA[DataWidth-1] == operandB[DataWidth-1])
		&& (sumWide[DataWidth-1] != operandA[DataWidth-1]);

	// Different input signs and result sign differs from A
	assign subOverflow = (operandA[DataWidth-1] != operandB[DataWidth-1])
		&& (diffWide[DataWidth-1] != operandA[DataWidth-1]);

	assign shiftAmount = operandB[4:0];
	// Magnitude 16 only comes from -16, and >> 16 clears everything
	assign shiftMag = -shiftAmount;

	// Negative amount is a logical right shift
	assign shiftResult = shiftAmount[4] ? (operandA >> shiftMag)
		: (operandA << shiftAmount[3:0]);

	// Data result
	always_comb
	begin
		case (aluOp)
			aluAdd:  result = sumWide[DataWidth-1:0];
			aluSub:  result = diffWide[DataWidth-1:0];
			aluCmp:  result = diffWide[DataWidth-1:0];
			aluAnd:  result = operandA & operandB;
			aluOr:   result = operandA | operandB;
			aluXor:  result = operandA ^ operandB;
			aluMov:  result = operandB;
			aluLsh:  result = shiftResult;
			aluLui:  result = {operandB[7:0], 8'h00};
			default: result = '0;
		endcase
	end

	// Flag values and which of them may change
	always_comb
	begin
		flagsNext = '0;
		flagMask  = '0;
		case (aluOp)
			aluAdd:
			begin
				flagsNext[FlagC] = sumWide[DataWidth];
				flagsNext[FlagF] = addOverflow;
				flagMask[FlagC]  = 1'b1;
				flagMask[FlagF]  = 1'b1;
			end
			aluSub:
			begin
				// Borrow shows up as the top bit of the wide difference
				flagsNext[FlagC] = diffWide[DataWidth];
				flagsNext[FlagF] = subOverflow;
				flagMask[FlagC]  = 1'b1;
				flagMask[FlagF]  = 1'b1;
			end
			aluCmp:
			begin
				flagsNext[FlagZ] = (operandA == operandB);
				flagsNext[FlagL] = (operandA < operandB);
				flagsNext[FlagN] = ($signed(operandA) < $signed(operandB));
				flagMask[FlagZ]  = 1'b1;
				flagMask[FlagL]  = 1'b1;
				flagMask[FlagN]  = 1'b1;
			end
			// Logic, shift, move and LUI keep all flags
			default:
			begin
				flagsNext = '0;
				flagMask  = '0;
			end
		endcase
	end

endmodule

/* verilog/cpuPkg.sv */
/*
 * Shared widths, opcode and extended-opcode encodings,
 * ALU operation enumeration and status flag bit positions
 */
package cpuPkg;

	// Data path and register file geometry
	localparam int DataWidth    = 16;
	localparam int RegCount     = 16;
	localparam int RegAddrWidth = 4;

	// Status register size
	localparam int FlagWidth = 5;

	// Primary opcodes, instruction bits 15..12
	localparam logic [3:0] OpRegGroup = 4'b0000;
	localparam logic [3:0] OpAndi     = 4'b0001;
	localparam logic [3:0] OpOri      = 4'b0010;
	localparam logic [3:0] OpXori     = 4'b0011;
	localparam logic [3:0] OpAddi     = 4'b0101;
	localparam logic [3:0] OpLshi     = 4'b1000;
	localparam logic [3:0] OpSubi     = 4'b1001;
	localparam logic [3:0] OpCmpi     = 4'b1011;
	localparam logic [3:0] OpMovi     = 4'b1101;
	localparam logic [3:0] OpLui      = 4'b1111;

	// Extended opcodes, bits 7..4 of a register-register word
	localparam logic [3:0] ExtAnd = 4'b0001;
	localparam logic [3:0] ExtOr  = 4'b0010;
	localparam logic [3:0] ExtXor = 4'b0011;
	localparam logic [3:0] ExtLsh = 4'b0100;
	localparam logic [3:0] ExtAdd = 4'b0101;
	localparam logic [3:0] ExtSub = 4'b1001;
	localparam logic [3:0] ExtCmp = 4'b1011;
	localparam logic [3:0] ExtMov = 4'b1101;

	// Operations the ALU knows how to carry out
	typedef enum logic [3:0] {
		aluNop,
		aluAdd,
		aluSub,
		aluCmp,
		aluAnd,
		aluOr,
		aluXor,
		aluMov,
		aluLsh,
		aluLui
	} aluOpT;

	// Bit positions inside the flag vector
	localparam int FlagC = 0;   // carry or borrow
	localparam int FlagF = 1;   // signed overflow
	localparam int FlagZ = 2;
	localparam int FlagL = 3;   // unsigned less than
	localparam int FlagN = 4;   // signed less than

endpackage

/* verilog/execCore.sv */
/*
 * Single-cycle execution core: decoder, register file,
 * ALU and status register with writeback monitor outputs
 */
module execCore import cpuPkg::*;
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic [15:0]             instr,
	input  logic                    instrValid,
	output logic                    wbValid,
	output logic [RegAddrWidth-1:0] wbAddr,
	output logic [DataWidth-1:0]    wbData,
	output logic [FlagWidth-1:0]    flags
);

	// Register read selects
	logic [RegAddrWidth-1:0] selectA;
	logic [RegAddrWidth-1:0] selectB;

	// Decoded control and immediate
	aluOpT                aluOp;
	logic                 useImm;
	logic [DataWidth-1:0] immValue;

	// Register read data
	logic [DataWidth-1:0] readA;
	logic [DataWidth-1:0] readB;

	// Second ALU operand
	logic [DataWidth-1:0] operandB;

	// Flag update from the ALU
	logic [FlagWidth-1:0] flagsNext;
	logic [FlagWidth-1:0] flagMask;

	// Writeback port signals double as the monitor outputs
	instrDecoder u_decoder (
		.instr       (instr),
		.instrValid  (instrValid),
		.selectA     (selectA),
		.selectB     (selectB),
		.writeSelect (wbAddr),
		.writeEnable (wbValid),
		.aluOp       (aluOp),
		.useImm      (useImm),
		.immValue    (immValue)
	);

	regFile u_regFile (
		.clk         (clk),
		.reset       (reset),
		.writeEnable (wbValid),
		.writeSelect (wbAddr),
		.writeValue  (wbData),
		.selectA     (selectA),
		.selectB     (selectB),
		.readA       (readA),
		.readB       (readB)
	);

	// Immediate or Rsrc
	assign operandB = useImm ? immValue : readB;

	alu u_alu (
		.operandA  (readA),
		.operandB  (operandB),
		.aluOp     (aluOp),
		.result    (wbData),
		.flagsNext (flagsNext),
		.flagMask  (flagMask)
	);

	statusReg u_statusReg (
		.clk       (clk),
		.reset     (reset),
		.flagsNext (flagsNext),
		.flagMask  (flagMask),
		.flags     (flags)
	);

endmodule

/* verilog/instrDecoder.sv */
/*
 * Instruction decoder: register selects, immediate
 * extension, ALU operation and write enable
 */
module instrDecoder import cpuPkg::*;
(
	input  logic [15:0]             instr,
	input  logic                    instrValid,
	output logic [RegAddrWidth-1:0] selectA,
	output logic [RegAddrWidth-1:0] selectB,
	output logic [RegAddrWidth-1:0] writeSelect,
	output logic                    writeEnable,
	output aluOpT                   aluOp,
	output logic                    useImm,
	output logic [DataWidth-1:0]    immValue
);

	// Instruction fields
	logic [3:0] opcode;
	logic [3:0] extOpcode;
	logic [7:0] imm8;

	// Immediate forms that take a signed byte
	logic signExtend;

	// Operation before the valid strobe is applied
	aluOpT decodedOp;

	assign opcode    = instr[15:12];
	assign extOpcode = instr[7:4];
	assign imm8      = instr[7:0];

	// Rdest is both the A operand and the destination
	assign selectA     = instr[11:8];
	assign writeSelect = instr[11:8];
	assign selectB     = instr[3:0];

	always_comb
	begin
		decodedOp  = aluNop;
		useImm     = 1'b1;
		signExtend = 1'b0;
		case (opcode)
			OpRegGroup:
			begin
				useImm = 1'b0;
				case (extOpcode)
					ExtAnd:  decodedOp = aluAnd;
					ExtOr:   decodedOp = aluOr;
					ExtXor:  decodedOp = aluXor;
					ExtLsh:  decodedOp = aluLsh;
					ExtAdd:  decodedOp = aluAdd;
					ExtSub:  decodedOp = aluSub;
					ExtCmp:  decodedOp = aluCmp;
					ExtMov:  decodedOp = aluMov;
					default: decodedOp = aluNop;
				endcase
			end
			OpAndi:  decodedOp = aluAnd;
			OpOri:   decodedOp = aluOr;
			OpXori:  decodedOp = aluXor;
			OpLshi:  decodedOp = aluLsh;
			OpLui:   decodedOp = aluLui;
			OpAddi:
			begin
				decodedOp  = aluAdd;
				signExtend = 1'b1;
			end
			OpSubi:
			begin
				decodedOp  = aluSub;
				signExtend = 1'b1;
			end
			OpCmpi:
			begin
				decodedOp  = aluCmp;
				signExtend = 1'b1;
			end
			OpMovi:
			begin
				decodedOp  = aluMov;
				signExtend = 1'b1;
			end
			default: decodedOp = aluNop;
		endcase
	end

	// Idle cycles turn into a no-op
	assign aluOp = instrValid ? decodedOp : aluNop;

	// Compare only touches flags, never Rdest
	assign writeEnable = (aluOp != aluNop) && (aluOp != aluCmp);

	// LUI moves the byte up inside the ALU
	assign immValue = signExtend ? {{(DataWidth-8){imm8[7]}}, imm8}
		: {{(DataWidth-8){1'b0}}, imm8};

endmodule

/* verilog/regFile.sv */
/*
 * Sixteen general purpose registers, one-hot
 * write decode and two combinational read ports
 */
module regFile import cpuPkg::*;
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    writeEnable,
	input  logic [RegAddrWidth-1:0] writeSelect,
	input  logic [DataWidth-1:0]    writeValue,
	input  logic [RegAddrWidth-1:0] selectA,
	input  logic [RegAddrWidth-1:0] selectB,
	output logic [DataWidth-1:0]    readA,
	output logic [DataWidth-1:0]    readB
);

	// Register bank
	logic [DataWidth-1:0] regs [RegCount];

	// One enable line per register
	logic [RegCount-1:0] writeDecode;

	always_comb
	begin
		writeDecode = '0;
		if (writeEnable)
			writeDecode[writeSelect] = 1'b1;
	end

	// Only the decoded register takes the new value
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < RegCount; i++)
		begin
			if (reset)
				regs[i] <= '0;
			else if (writeDecode[i])
				regs[i] <= writeValue;
		end
	end

	// Port A mux, usually Rdest
	always_comb
	begin
		readA = regs[selectA];
	end

	// Port B mux, usually Rsrc
	always_comb
	begin
		readB = regs[selectB];
	end

endmodule

/* verilog/statusReg.sv */
/*
 * Processor status register with per-flag load mask
 */
module statusReg import cpuPkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic [FlagWidth-1:0] flagsNext,
	input  logic [FlagWidth-1:0] flagMask,
	output logic [FlagWidth-1:0] flags
);

	// Masked merge of new and held flag values
	logic [FlagWidth-1:0] flagsMerged;

	always_comb
	begin
		for (int i = 0; i < FlagWidth; i++)
		begin
			// Unselected bits keep their old state
			if (flagMask[i])
				flagsMerged[i] = flagsNext[i];
			else
				flagsMerged[i] = flags[i];
		end
	end

	// All flags clear on reset
	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= flagsMerged;
	end

endmodule
